// ==== logic/lumaRecon_defines.svh ====
/*
 * Luma reconstruction shared constants
 * Block size, sample and coefficient widths, and the quantizer
 * fixed-point shift and level limit
 */

`ifndef LUMA_RECON_DEFINES_SVH
`define LUMA_RECON_DEFINES_SVH

// Samples per 4x4 block
`define LR_BLK_PIX 16

// ----------------------------------------
// Element widths
// ----------------------------------------
`define LR_PIX_W 8
`define LR_COEFF_W 16
`define LR_LEVEL_W 12

// ----------------------------------------
// Quantizer
// ----------------------------------------
// Fixed-point shift applied after coeff * iq + bias
`define LR_QFIX 17
// Largest level magnitude
`define LR_MAX_LEVEL 2047

`endif

// ==== logic/lumaRecon_pkg.sv ====
/*
 * Luma reconstruction types
 * Element types of the flat block vectors and the states of the
 * top-level handshake controllers
 */

`default_nettype none

`include "lumaRecon_defines.svh"

package lumaRecon_pkg;

    // One unsigned luma sample
    typedef logic [`LR_PIX_W-1:0] pixel_t;

    // Transform or dequantized coefficient
    typedef logic signed [`LR_COEFF_W-1:0] coeff_t;

    // Quantized level
    typedef logic signed [`LR_LEVEL_W-1:0] level_t;

    // Input side uses IDLE, RUN and WAIT_REQ_LOW,
    // output side uses IDLE, OUT_REQ and OUT_WAIT_ACK_LOW
    typedef enum logic [2:0] {
        HS_IDLE,
        HS_RUN,
        HS_WAIT_REQ_LOW,
        HS_OUT_REQ,
        HS_OUT_WAIT_ACK_LOW
    } hsState_e;

endpackage

`default_nettype wire

// ==== logic/forwardDct4x4.sv ====
/*
 * Forward 4x4 integer DCT
 * Forms the residual of source minus prediction, then runs the
 * row pass and the column pass in two registered cycles
 */

`timescale 1ns/1ps
`default_nettype none

`include "lumaRecon_defines.svh"

module forwardDct4x4 (
    input  logic                                 clk,
    input  logic                                 rstN_i,
    input  logic                                 start_i,
    input  logic [`LR_BLK_PIX*`LR_PIX_W-1:0]     srcBlk_i,
    input  logic [`LR_BLK_PIX*`LR_PIX_W-1:0]     predBlk_i,
    output logic [`LR_BLK_PIX*`LR_COEFF_W-1:0]   coeffBlk_o,
    output logic [`LR_BLK_PIX*`LR_PIX_W-1:0]     predBlk_o,
    output logic                                 done_o
);

    lumaRecon_pkg::coeff_t rowD [`LR_BLK_PIX];
    lumaRecon_pkg::coeff_t rowQ [`LR_BLK_PIX];
    lumaRecon_pkg::coeff_t colD [`LR_BLK_PIX];
    logic [`LR_BLK_PIX*`LR_PIX_W-1:0] predQ;
    logic rowValidQ;

    function automatic int pix(input logic [`LR_BLK_PIX*`LR_PIX_W-1:0] blk, input int idx);
        lumaRecon_pkg::pixel_t p;
        p = blk[idx*`LR_PIX_W +: `LR_PIX_W];
        return int'(p);
    endfunction

    // ----------------------------------------
    // Row pass on the residual
    // ----------------------------------------
    always_comb begin
        int d0, d1, d2, d3;
        int a0, a1, a2, a3;
        for (int r = 0; r < 4; r++) begin
            d0 = pix(srcBlk_i, r * 4) - pix(predBlk_i, r * 4);
            d1 = pix(srcBlk_i, r * 4 + 1) - pix(predBlk_i, r * 4 + 1);
            d2 = pix(srcBlk_i, r * 4 + 2) - pix(predBlk_i, r * 4 + 2);
            d3 = pix(srcBlk_i, r * 4 + 3) - pix(predBlk_i, r * 4 + 3);
            a0 = d0 + d3;
            a1 = d1 + d2;
            a2 = d1 - d2;
            a3 = d0 - d3;
            rowD[r * 4]     = lumaRecon_pkg::coeff_t'((a0 + a1) * 8);
            rowD[r * 4 + 1] = lumaRecon_pkg::coeff_t'((a2 * 2217 + a3 * 5352 + 1812) >>> 9);
            rowD[r * 4 + 2] = lumaRecon_pkg::coeff_t'((a0 - a1) * 8);
            rowD[r * 4 + 3] = lumaRecon_pkg::coeff_t'((a3 * 2217 - a2 * 5352 + 937) >>> 9);
        end
    end

    // ----------------------------------------
    // Column pass on the row register
    // ----------------------------------------
    always_comb begin
        int a0, a1, a2, a3;
        for (int c = 0; c < 4; c++) begin
            a0 = int'(rowQ[c]) + int'(rowQ[12 + c]);
            a1 = int'(rowQ[4 + c]) + int'(rowQ[8 + c]);
            a2 = int'(rowQ[4 + c]) - int'(rowQ[8 + c]);
            a3 = int'(rowQ[c]) - int'(rowQ[12 + c]);
            colD[c]      = lumaRecon_pkg::coeff_t'((a0 + a1 + 7) >>> 4);
            // Row 1 gets one extra when its a3 term is nonzero
            colD[4 + c]  = lumaRecon_pkg::coeff_t'(((a2 * 2217 + a3 * 5352 + 12000) >>> 16)
                                                   + ((a3 != 0) ? 1 : 0));
            colD[8 + c]  = lumaRecon_pkg::coeff_t'((a0 - a1 + 7) >>> 4);
            colD[12 + c] = lumaRecon_pkg::coeff_t'((a3 * 2217 - a2 * 5352 + 51000) >>> 16);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            rowValidQ <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            rowValidQ <= start_i;
            done_o    <= rowValidQ;
        end
    end

    // Stage payload, prediction follows the data
    always_ff @(posedge clk) begin
        if (start_i) begin
            rowQ  <= rowD;
            predQ <= predBlk_i;
        end
        if (rowValidQ) begin
            for (int i = 0; i < `LR_BLK_PIX; i++) begin
                coeffBlk_o[i*`LR_COEFF_W +: `LR_COEFF_W] <= colD[i];
            end
            predBlk_o <= predQ;
        end
    end

endmodule

`default_nettype wire

// ==== logic/blockQuantizer.sv ====
/*
 * Block quantizer
 * Dead-zone quantization with sharpening and level clamping,
 * plus the matching dequantized coefficients, in one cycle
 */

`timescale 1ns/1ps
`default_nettype none

`include "lumaRecon_defines.svh"

module blockQuantizer (
    input  logic                                 clk,
    input  logic                                 rstN_i,
    input  logic                                 start_i,
    input  logic [`LR_BLK_PIX*`LR_COEFF_W-1:0]   coeffBlk_i,
    input  logic [`LR_BLK_PIX*`LR_PIX_W-1:0]     predBlk_i,
    input  logic [15:0]                          qDc_i,
    input  logic [15:0]                          qAc_i,
    input  logic [15:0]                          iqDc_i,
    input  logic [15:0]                          iqAc_i,
    input  logic [31:0]                          biasDc_i,
    input  logic [31:0]                          biasAc_i,
    input  logic [31:0]                          zthreshDc_i,
    input  logic [31:0]                          zthreshAc_i,
    input  logic [15:0]                          sharpenDc_i,
    input  logic [15:0]                          sharpenAc_i,
    output logic [`LR_BLK_PIX*`LR_LEVEL_W-1:0]   levelBlk_o,
    output logic [`LR_BLK_PIX*`LR_COEFF_W-1:0]   dequantBlk_o,
    output logic [`LR_BLK_PIX*`LR_PIX_W-1:0]     predBlk_o,
    output logic                                 done_o
);

    lumaRecon_pkg::level_t levelD [`LR_BLK_PIX];
    lumaRecon_pkg::coeff_t dqD [`LR_BLK_PIX];

    always_comb begin
        lumaRecon_pkg::coeff_t c;
        int ci;
        int lvl;
        logic neg;
        logic [15:0] q, iq, sharpen;
        logic [31:0] bias, zthresh, sum;
        logic [63:0] scaled;
        for (int n = 0; n < `LR_BLK_PIX; n++) begin
            // Position 0 is DC, the rest AC
            q       = (n == 0) ? qDc_i : qAc_i;
            iq      = (n == 0) ? iqDc_i : iqAc_i;
            bias    = (n == 0) ? biasDc_i : biasAc_i;
            zthresh = (n == 0) ? zthreshDc_i : zthreshAc_i;
            sharpen = (n == 0) ? sharpenDc_i : sharpenAc_i;

            c   = coeffBlk_i[n*`LR_COEFF_W +: `LR_COEFF_W];
            ci  = int'(c);
            neg = (ci < 0);
            sum = 32'(neg ? -ci : ci) + 32'(sharpen);

            scaled = (64'(sum) * 64'(iq) + 64'(bias)) >> `LR_QFIX;
            if (scaled > 64'(`LR_MAX_LEVEL)) begin
                scaled = 64'(`LR_MAX_LEVEL);
            end
            lvl = int'(scaled[`LR_LEVEL_W-1:0]);

            // Inside the dead zone the level is zero
            if (sum <= zthresh) begin
                lvl = 0;
            end else if (neg) begin
                lvl = -lvl;
            end
            levelD[n] = lumaRecon_pkg::level_t'(lvl);
            dqD[n]    = lumaRecon_pkg::coeff_t'(lvl * int'(q));
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            done_o <= 1'b0;
        end else begin
            done_o <= start_i;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            for (int i = 0; i < `LR_BLK_PIX; i++) begin
                levelBlk_o[i*`LR_LEVEL_W +: `LR_LEVEL_W]   <= levelD[i];
                dequantBlk_o[i*`LR_COEFF_W +: `LR_COEFF_W] <= dqD[i];
            end
            predBlk_o <= predBlk_i;
        end
    end

endmodule

`default_nettype wire

// ==== logic/inverseDct4x4.sv ====
/*
 * Inverse 4x4 integer transform
 * Vertical pass, then horizontal pass with rounding, prediction
 * add and clipping to 8-bit samples
 */

`timescale 1ns/1ps
`default_nettype none

`include "lumaRecon_defines.svh"

module inverseDct4x4 (
    input  logic                                 clk,
    input  logic                                 rstN_i,
    input  logic                                 start_i,
    input  logic [`LR_BLK_PIX*`LR_COEFF_W-1:0]   dequantBlk_i,
    input  logic [`LR_BLK_PIX*`LR_PIX_W-1:0]     predBlk_i,
    output logic [`LR_BLK_PIX*`LR_PIX_W-1:0]     reconBlk_o,
    output logic                                 done_o
);

    // Vertical results need a few bits over a coefficient
    typedef logic signed [`LR_COEFF_W+3:0] vert_t;

    vert_t vertD [`LR_BLK_PIX];
    vert_t vertQ [`LR_BLK_PIX];
    lumaRecon_pkg::pixel_t reconD [`LR_BLK_PIX];
    logic [`LR_BLK_PIX*`LR_PIX_W-1:0] predQ;
    logic vertValidQ;

    // a * (1 + 20091/65536)
    function automatic int mul1(input int a);
        longint p;
        p = longint'(a) * 20091;
        return int'(p >>> 16) + a;
    endfunction

    // a * 35468/65536
    function automatic int mul2(input int a);
        longint p;
        p = longint'(a) * 35468;
        return int'(p >>> 16);
    endfunction

    function automatic int coeffAt(input logic [`LR_BLK_PIX*`LR_COEFF_W-1:0] blk, input int idx);
        lumaRecon_pkg::coeff_t c;
        c = blk[idx*`LR_COEFF_W +: `LR_COEFF_W];
        return int'(c);
    endfunction

    // ----------------------------------------
    // Vertical pass, one column per step
    // ----------------------------------------
    always_comb begin
        int a, b, c, d;
        for (int i = 0; i < 4; i++) begin
            a = coeffAt(dequantBlk_i, i) + coeffAt(dequantBlk_i, 8 + i);
            b = coeffAt(dequantBlk_i, i) - coeffAt(dequantBlk_i, 8 + i);
            c = mul2(coeffAt(dequantBlk_i, 4 + i)) - mul1(coeffAt(dequantBlk_i, 12 + i));
            d = mul1(coeffAt(dequantBlk_i, 4 + i)) + mul2(coeffAt(dequantBlk_i, 12 + i));
            // Stored transposed, column i in entries 4i..4i+3
            vertD[i * 4]     = vert_t'(a + d);
            vertD[i * 4 + 1] = vert_t'(b + c);
            vertD[i * 4 + 2] = vert_t'(b - c);
            vertD[i * 4 + 3] = vert_t'(a - d);
        end
    end

    // ----------------------------------------
    // Horizontal pass and reconstruction
    // ----------------------------------------
    always_comb begin
        int dc, a, b, c, d, v;
        int s [4];
        lumaRecon_pkg::pixel_t p;
        for (int r = 0; r < 4; r++) begin
            dc = int'(vertQ[r]) + 4;
            a  = dc + int'(vertQ[8 + r]);
            b  = dc - int'(vertQ[8 + r]);
            c  = mul2(int'(vertQ[4 + r])) - mul1(int'(vertQ[12 + r]));
            d  = mul1(int'(vertQ[4 + r])) + mul2(int'(vertQ[12 + r]));
            s[0] = a + d;
            s[1] = b + c;
            s[2] = b - c;
            s[3] = a - d;
            for (int x = 0; x < 4; x++) begin
                p = predQ[(r * 4 + x)*`LR_PIX_W +: `LR_PIX_W];
                v = (s[x] >>> 3) + int'(p);
                // Clip to the sample range
                if (v < 0) begin
                    v = 0;
                end else if (v > 255) begin
                    v = 255;
                end
                reconD[r * 4 + x] = lumaRecon_pkg::pixel_t'(v);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            vertValidQ <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            vertValidQ <= start_i;
            done_o     <= vertValidQ;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            vertQ <= vertD;
            predQ <= predBlk_i;
        end
        if (vertValidQ) begin
            for (int i = 0; i < `LR_BLK_PIX; i++) begin
                reconBlk_o[i*`LR_PIX_W +: `LR_PIX_W] <= reconD[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/lumaRecon.sv ====
/*
 * Luma 4x4 reconstruction path
 * Four-phase handshakes on both sides around the forward DCT,
 * quantizer and inverse DCT pipeline
 */

`timescale 1ns/1ps
`default_nettype none

`include "lumaRecon_defines.svh"

module lumaRecon (
    input  logic                                 clk,
    input  logic                                 rstN_i,
    input  logic                                 reqIn_i,
    output logic                                 ackIn_o,
    input  logic [`LR_BLK_PIX*`LR_PIX_W-1:0]     srcBlk_i,
    input  logic [`LR_BLK_PIX*`LR_PIX_W-1:0]     predBlk_i,
    input  logic [15:0]                          qDc_i,
    input  logic [15:0]                          qAc_i,
    input  logic [15:0]                          iqDc_i,
    input  logic [15:0]                          iqAc_i,
    input  logic [31:0]                          biasDc_i,
    input  logic [31:0]                          biasAc_i,
    input  logic [31:0]                          zthreshDc_i,
    input  logic [31:0]                          zthreshAc_i,
    input  logic [15:0]                          sharpenDc_i,
    input  logic [15:0]                          sharpenAc_i,
    output logic                                 reqOut_o,
    input  logic                                 ackOut_i,
    output logic [`LR_BLK_PIX*`LR_PIX_W-1:0]     reconBlk_o,
    output logic [`LR_BLK_PIX*`LR_LEVEL_W-1:0]   levelBlk_o
);

    // One block in the output register, one more in the pipeline
    // or parked at the inverse DCT output
    localparam logic [1:0] MAX_BLOCKS = 2'd2;

    lumaRecon_pkg::hsState_e inState, outState;
    logic [`LR_BLK_PIX*`LR_PIX_W-1:0] srcQ, predQ;
    logic [1:0] blkCnt;
    logic accept, deliver, loadOut, pendingQ, fdctStart;

    logic [`LR_BLK_PIX*`LR_COEFF_W-1:0] fdctCoeff, quantDq;
    logic [`LR_BLK_PIX*`LR_PIX_W-1:0] fdctPred, quantPred, idctRecon;
    logic [`LR_BLK_PIX*`LR_LEVEL_W-1:0] quantLevel, levelSkidQ;
    logic fdctDone, quantDone, idctDone;

    assign accept    = (inState == lumaRecon_pkg::HS_IDLE) && reqIn_i && (blkCnt < MAX_BLOCKS);
    assign fdctStart = (inState == lumaRecon_pkg::HS_RUN);
    assign deliver   = (outState == lumaRecon_pkg::HS_OUT_WAIT_ACK_LOW) && !ackOut_i;
    assign loadOut   = ((outState == lumaRecon_pkg::HS_IDLE) || deliver)
                       && (idctDone || pendingQ);

    // ----------------------------------------
    // Input handshake
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            inState <= lumaRecon_pkg::HS_IDLE;
            ackIn_o <= 1'b0;
        end else begin
            case (inState)
                lumaRecon_pkg::HS_IDLE: if (accept) begin
                    ackIn_o <= 1'b1;
                    inState <= lumaRecon_pkg::HS_RUN;
                end
                // Start pulse is issued here
                lumaRecon_pkg::HS_RUN: inState <= lumaRecon_pkg::HS_WAIT_REQ_LOW;
                lumaRecon_pkg::HS_WAIT_REQ_LOW: if (!reqIn_i) begin
                    ackIn_o <= 1'b0;
                    inState <= lumaRecon_pkg::HS_IDLE;
                end
                default: inState <= lumaRecon_pkg::HS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            srcQ  <= srcBlk_i;
            predQ <= predBlk_i;
        end
    end

    // Blocks accepted and not yet handed to the sink
    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            blkCnt <= '0;
        end else if (accept && !deliver) begin
            blkCnt <= blkCnt + 2'd1;
        end else if (deliver && !accept) begin
            blkCnt <= blkCnt - 2'd1;
        end
    end

    // ----------------------------------------
    // Pipeline
    // ----------------------------------------
    forwardDct4x4 u_fdct (
        .clk        (clk),
        .rstN_i     (rstN_i),
        .start_i    (fdctStart),
        .srcBlk_i   (srcQ),
        .predBlk_i  (predQ),
        .coeffBlk_o (fdctCoeff),
        .predBlk_o  (fdctPred),
        .done_o     (fdctDone)
    );

    blockQuantizer u_quant (
        .clk          (clk),
        .rstN_i       (rstN_i),
        .start_i      (fdctDone),
        .coeffBlk_i   (fdctCoeff),
        .predBlk_i    (fdctPred),
        .qDc_i        (qDc_i),
        .qAc_i        (qAc_i),
        .iqDc_i       (iqDc_i),
        .iqAc_i       (iqAc_i),
        .biasDc_i     (biasDc_i),
        .biasAc_i     (biasAc_i),
        .zthreshDc_i  (zthreshDc_i),
        .zthreshAc_i  (zthreshAc_i),
        .sharpenDc_i  (sharpenDc_i),
        .sharpenAc_i  (sharpenAc_i),
        .levelBlk_o   (quantLevel),
        .dequantBlk_o (quantDq),
        .predBlk_o    (quantPred),
        .done_o       (quantDone)
    );

    inverseDct4x4 u_idct (
        .clk          (clk),
        .rstN_i       (rstN_i),
        .start_i      (quantDone),
        .dequantBlk_i (quantDq),
        .predBlk_i    (quantPred),
        .reconBlk_o   (idctRecon),
        .done_o       (idctDone)
    );

    // Levels wait here while the inverse DCT runs
    always_ff @(posedge clk) begin
        if (quantDone) begin
            levelSkidQ <= quantLevel;
        end
    end

    // ----------------------------------------
    // Output register and handshake
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            outState <= lumaRecon_pkg::HS_IDLE;
            reqOut_o <= 1'b0;
            pendingQ <= 1'b0;
        end else begin
            // A finished block parks at the inverse DCT output
            if (loadOut) begin
                pendingQ <= 1'b0;
            end else if (idctDone) begin
                pendingQ <= 1'b1;
            end
            case (outState)
                lumaRecon_pkg::HS_IDLE, lumaRecon_pkg::HS_OUT_WAIT_ACK_LOW: begin
                    if (loadOut) begin
                        reqOut_o <= 1'b1;
                        outState <= lumaRecon_pkg::HS_OUT_REQ;
                    end else if (deliver) begin
                        outState <= lumaRecon_pkg::HS_IDLE;
                    end
                end
                lumaRecon_pkg::HS_OUT_REQ: if (ackOut_i) begin
                    reqOut_o <= 1'b0;
                    outState <= lumaRecon_pkg::HS_OUT_WAIT_ACK_LOW;
                end
                default: outState <= lumaRecon_pkg::HS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (loadOut) begin
            reconBlk_o <= idctRecon;
            levelBlk_o <= levelSkidQ;
        end
    end

endmodule

`default_nettype wire

// ==== bench/clockGen.sv ====
/*
 * Testbench clock source
 * Free-running clock with a 4 ns period
 */

`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int HALF_PERIOD_NS = 2
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

// ==== bench/lumaRecon_tb.sv ====
/*
 * Luma reconstruction testbench
 * Applies a table of blocks and quantizer settings through the input
 * handshake and checks levels and reconstruction from a reference model
 */

`timescale 1ns/1ps
`default_nettype none

`include "lumaRecon_defines.svh"

module lumaRecon_tb;

    localparam int PIX_BITS = `LR_BLK_PIX * `LR_PIX_W;
    localparam int LVL_BITS = `LR_BLK_PIX * `LR_LEVEL_W;
    localparam int MAX_ENTRIES = 64;

    typedef struct packed {
        logic [15:0] qDc;
        logic [15:0] qAc;
        logic [15:0] iqDc;
        logic [15:0] iqAc;
        logic [31:0] biasDc;
        logic [31:0] biasAc;
        logic [31:0] zDc;
        logic [31:0] zAc;
        logic [15:0] shDc;
        logic [15:0] shAc;
    } qSet_t;

    logic clk, rstN, reqIn, ackIn, reqOut, ackOut;
    logic [PIX_BITS-1:0] srcBlk, predBlk, reconBlk;
    logic [LVL_BITS-1:0] levelBlk;
    qSet_t settings;

    // Stimulus table with expected results
    string tName [MAX_ENTRIES];
    logic [PIX_BITS-1:0] tSrc [MAX_ENTRIES];
    logic [PIX_BITS-1:0] tPred [MAX_ENTRIES];
    qSet_t tSet [MAX_ENTRIES];
    logic [LVL_BITS-1:0] tLevel [MAX_ENTRIES];
    logic [PIX_BITS-1:0] tRecon [MAX_ENTRIES];
    int tStall [MAX_ENTRIES];
    int numEntries = 0;
    int sent = 0;
    int received = 0;
    int cycleCount = 0;

    clockGen c0 (.clk_o(clk));

    lumaRecon dut0 (
        .clk         (clk),
        .rstN_i      (rstN),
        .reqIn_i     (reqIn),
        .ackIn_o     (ackIn),
        .srcBlk_i    (srcBlk),
        .predBlk_i   (predBlk),
        .qDc_i       (settings.qDc),
        .qAc_i       (settings.qAc),
        .iqDc_i      (settings.iqDc),
        .iqAc_i      (settings.iqAc),
        .biasDc_i    (settings.biasDc),
        .biasAc_i    (settings.biasAc),
        .zthreshDc_i (settings.zDc),
        .zthreshAc_i (settings.zAc),
        .sharpenDc_i (settings.shDc),
        .sharpenAc_i (settings.shAc),
        .reqOut_o    (reqOut),
        .ackOut_i    (ackOut),
        .reconBlk_o  (reconBlk),
        .levelBlk_o  (levelBlk)
    );

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    // a * sqrt(2) * cos(pi/8)
    function automatic int scaleCos8(input int a);
        return int'((longint'(a) * 20091) >>> 16) + a;
    endfunction

    // a * sqrt(2) * sin(pi/8)
    function automatic int scaleSin8(input int a);
        return int'((longint'(a) * 35468) >>> 16);
    endfunction

    function automatic void modelBlock(input logic [PIX_BITS-1:0] src,
                                       input logic [PIX_BITS-1:0] pred, input qSet_t s,
                                       output logic [LVL_BITS-1:0] lv,
                                       output logic [PIX_BITS-1:0] rc);
        int t [16];
        int f [16];
        int g [16];
        int d [4];
        int a, b, c, e;
        longint mag, lvl, q;
        // Residual and forward row pass
        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < 4; k++) begin
                d[k] = int'(src[(r * 4 + k) * 8 +: 8]) - int'(pred[(r * 4 + k) * 8 +: 8]);
            end
            a = d[0] + d[3];
            b = d[1] + d[2];
            c = d[1] - d[2];
            e = d[0] - d[3];
            t[r * 4] = (a + b) * 8;
            t[r * 4 + 1] = (c * 2217 + e * 5352 + 1812) >>> 9;
            t[r * 4 + 2] = (a - b) * 8;
            t[r * 4 + 3] = (e * 2217 - c * 5352 + 937) >>> 9;
        end
        for (int i = 0; i < 4; i++) begin
            a = t[i] + t[12 + i];
            b = t[4 + i] + t[8 + i];
            c = t[4 + i] - t[8 + i];
            e = t[i] - t[12 + i];
            f[i] = (a + b + 7) >>> 4;
            f[4 + i] = ((c * 2217 + e * 5352 + 12000) >>> 16) + ((e != 0) ? 1 : 0);
            f[8 + i] = (a - b + 7) >>> 4;
            f[12 + i] = (e * 2217 - c * 5352 + 51000) >>> 16;
        end
        // Dead-zone quantizer, DC at position 0
        for (int n = 0; n < 16; n++) begin
            mag = longint'((f[n] < 0) ? -f[n] : f[n]) + longint'((n == 0) ? s.shDc : s.shAc);
            q = longint'((n == 0) ? s.qDc : s.qAc);
            lvl = 0;
            if (mag > longint'((n == 0) ? s.zDc : s.zAc)) begin
                lvl = (mag * longint'((n == 0) ? s.iqDc : s.iqAc)
                       + longint'((n == 0) ? s.biasDc : s.biasAc)) >>> `LR_QFIX;
                if (lvl > longint'(`LR_MAX_LEVEL)) begin
                    lvl = longint'(`LR_MAX_LEVEL);
                end
                if (f[n] < 0) begin
                    lvl = -lvl;
                end
            end
            lv[n * 12 +: 12] = 12'(lvl);
            g[n] = int'(shortint'(lvl * q));
        end
        // Inverse, columns first, stored transposed
        for (int i = 0; i < 4; i++) begin
            a = g[i] + g[8 + i];
            b = g[i] - g[8 + i];
            c = scaleSin8(g[4 + i]) - scaleCos8(g[12 + i]);
            e = scaleCos8(g[4 + i]) + scaleSin8(g[12 + i]);
            t[i * 4] = a + e;
            t[i * 4 + 1] = b + c;
            t[i * 4 + 2] = b - c;
            t[i * 4 + 3] = a - e;
        end
        for (int r = 0; r < 4; r++) begin
            a = t[r] + 4 + t[8 + r];
            b = t[r] + 4 - t[8 + r];
            c = scaleSin8(t[4 + r]) - scaleCos8(t[12 + r]);
            e = scaleCos8(t[4 + r]) + scaleSin8(t[12 + r]);
            d[0] = a + e;
            d[1] = b + c;
            d[2] = b - c;
            d[3] = a - e;
            for (int k = 0; k < 4; k++) begin
                d[k] = (d[k] >>> 3) + int'(pred[(r * 4 + k) * 8 +: 8]);
                d[k] = (d[k] < 0) ? 0 : ((d[k] > 255) ? 255 : d[k]);
                rc[(r * 4 + k) * 8 +: 8] = 8'(d[k]);
            end
        end
    endfunction

    // ----------------------------------------
    // Table construction
    // ----------------------------------------
    // Settings as a host would derive them from q
    function automatic qSet_t makeSettings(input int qd, input int qa, input int sharp);
        qSet_t s;
        int iqd, iqa;
        iqd = (131072 / qd > 65535) ? 65535 : 131072 / qd;
        iqa = (131072 / qa > 65535) ? 65535 : 131072 / qa;
        s.qDc = 16'(qd);
        s.qAc = 16'(qa);
        s.iqDc = 16'(iqd);
        s.iqAc = 16'(iqa);
        s.biasDc = 32'(96 << 9);
        s.biasAc = 32'(110 << 9);
        s.zDc = 32'((131071 - (96 << 9)) / iqd);
        s.zAc = 32'((131071 - (110 << 9)) / iqa);
        s.shDc = 16'(sharp);
        s.shAc = 16'(sharp);
        return s;
    endfunction

    // Kind 0 flat, 1 ramp, otherwise checkerboard
    function automatic logic [PIX_BITS-1:0] patternBlock(input int kind, input int lo,
                                                         input int hi);
        logic [PIX_BITS-1:0] blk;
        for (int k = 0; k < 16; k++) begin
            case (kind)
                0: blk[k * 8 +: 8] = 8'(lo);
                1: blk[k * 8 +: 8] = 8'(lo + (hi - lo) * k / 15);
                default: blk[k * 8 +: 8] = 8'((((k >> 2) + k) % 2 == 1) ? hi : lo);
            endcase
        end
        return blk;
    endfunction

    function automatic logic [PIX_BITS-1:0] randomBlock();
        logic [PIX_BITS-1:0] blk;
        for (int k = 0; k < 4; k++) begin
            blk[k * 32 +: 32] = $urandom;
        end
        return blk;
    endfunction

    function automatic void addEntry(input string name, input logic [PIX_BITS-1:0] src,
                                     input logic [PIX_BITS-1:0] pred, input qSet_t s,
                                     input int stall);
        logic [LVL_BITS-1:0] lv;
        logic [PIX_BITS-1:0] rc;
        modelBlock(src, pred, s, lv, rc);
        tName[numEntries] = name;
        tSrc[numEntries] = src;
        tPred[numEntries] = pred;
        tSet[numEntries] = s;
        tLevel[numEntries] = lv;
        tRecon[numEntries] = rc;
        tStall[numEntries] = stall;
        numEntries++;
    endfunction

    function automatic void buildTable();
        qSet_t s;
        logic [PIX_BITS-1:0] rb;
        void'($urandom(32'h527d4756));
        s = makeSettings(4, 8, 0);
        rb = randomBlock();
        addEntry("same_random", rb, rb, s, int'($urandom % 21));
        addEntry("same_flat", patternBlock(0, 77, 0), patternBlock(0, 77, 0), s, 0);
        s = makeSettings(1, 1, 0);
        addEntry("flat", patternBlock(0, 140, 0), patternBlock(0, 100, 0), s,
                 int'($urandom % 21));
        addEntry("ramp", patternBlock(1, 10, 250), patternBlock(0, 128, 0), s,
                 int'($urandom % 21));
        addEntry("checker", patternBlock(2, 40, 200), patternBlock(0, 120, 0), s,
                 int'($urandom % 21));
        // Fine steps would give nonzero levels without the raised threshold
        s = makeSettings(1, 1, 0);
        s.zDc = 32'h0000_ffff;
        s.zAc = 32'h0000_ffff;
        addEntry("dead_zone", patternBlock(2, 99, 101), patternBlock(0, 100, 0), s, 2);
        // Saturating levels of both signs
        s = makeSettings(8, 8, 65535);
        s.iqDc = 16'hffff;
        s.iqAc = 16'hffff;
        addEntry("clamp_pos", patternBlock(0, 255, 0), patternBlock(0, 0, 0), s, 1);
        addEntry("clamp_neg", patternBlock(0, 0, 0), patternBlock(0, 255, 0), s, 1);
        s = makeSettings(6, 10, 2);
        for (int k = 0; k < 6; k++) begin
            addEntry($sformatf("backpressure_%0d", k), randomBlock(), randomBlock(), s, 20);
        end
        for (int k = 0; k < 40; k++) begin
            if (k % 4 == 0) begin
                s = makeSettings(3 + int'($urandom % 60), 3 + int'($urandom % 100),
                                 int'($urandom % 8));
                // DC sharpening kept apart from the AC value
                s.shDc = 16'(8 + $urandom % 8);
            end
            addEntry($sformatf("random_%0d", k), randomBlock(), randomBlock(), s,
                     int'($urandom % 21));
        end
    endfunction

    // ----------------------------------------
    // Handshakes and checks
    // ----------------------------------------
    task automatic checkValue(input string testName, input string what,
                              input logic [LVL_BITS-1:0] expected,
                              input logic [LVL_BITS-1:0] actual);
        if (expected !== actual) begin
            $display("error %s %s: expected %h actual %h", testName, what, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic sendBlock(input int idx);
        @(posedge clk);
        srcBlk <= tSrc[idx];
        predBlk <= tPred[idx];
        reqIn <= 1'b1;
        do @(posedge clk); while (!ackIn);
        reqIn <= 1'b0;
        do @(posedge clk); while (ackIn);
    endtask

    task automatic receiveBlocks();
        forever begin
            @(posedge clk);
            if (reqOut) begin
                if (received >= numEntries) begin
                    $display("SOME TESTS FAILED");
                    $fatal(1, "DUT produced an output block beyond the last table entry");
                end
                repeat (tStall[received]) @(posedge clk);
                checkValue(tName[received], "levels", tLevel[received], levelBlk);
                checkValue(tName[received], "recon", 192'(tRecon[received]), 192'(reconBlk));
                ackOut <= 1'b1;
                do @(posedge clk); while (reqOut);
                ackOut <= 1'b0;
                received++;
            end
        end
    endtask

    initial begin
        receiveBlocks();
    end

    // Limit scales with the table length
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= 40 * numEntries + 100) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "run timed out after %0d cycles", cycleCount);
        end
    end

    initial begin
        rstN = 1'b0;
        reqIn = 1'b0;
        ackOut = 1'b0;
        srcBlk = '0;
        predBlk = '0;
        settings = '0;
        buildTable();
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        for (int i = 0; i < numEntries; i++) begin
            // New settings only once the pipeline has drained
            if (tSet[i] != settings) begin
                while (received != sent) @(posedge clk);
                @(posedge clk);
                settings <= tSet[i];
            end
            sendBlock(i);
            sent++;
        end
        while (received != sent) @(posedge clk);
        repeat (20) @(posedge clk);
        if (received == numEntries && !reqOut) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("SOME TESTS FAILED");
            $fatal(1, "output block count does not match the table");
        end
    end

endmodule

`default_nettype wire

// ==== lumaRecon.f ====
+incdir+logic
logic/lumaRecon_pkg.sv
logic/forwardDct4x4.sv
logic/blockQuantizer.sv
logic/inverseDct4x4.sv
logic/lumaRecon.sv
bench/clockGen.sv
bench/lumaRecon_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the luma reconstruction testbench with Verilator and runs it.
# Exits with the simulator's status.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module lumaRecon_tb -f lumaRecon.f \
    -Mdir obj_dir -o lumaRecon_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status" >&2
    exit "$status"
fi

./obj_dir/lumaRecon_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status" >&2
    exit "$status"
fi

exit 0
